/* vid_timing_pkg.sv */
`default_nettype none

package vid_timing_pkg;

	localparam int CNT_W = 11; // Every raster count

	typedef enum logic [2:0] {
		MODE_VGA,
		MODE_SVGA,
		MODE_XGA,
		MODE_HDTV720P,
		MODE_SXGA,
		MODE_CAMERA
	} vid_mode_e;

	////////////////////////////////////////
	// Per-mode timing in pixels and lines
	////////////////////////////////////////

	// 640x480@60
	localparam logic [CNT_W-1:0] HPIXELS_VGA = 11'd640;
	localparam logic [CNT_W-1:0] HFNPRCH_VGA = 11'd16;
	localparam logic [CNT_W-1:0] HSYNCPW_VGA = 11'd96;
	localparam logic [CNT_W-1:0] HBKPRCH_VGA = 11'd48;
	localparam logic [CNT_W-1:0] VLINES_VGA  = 11'd480;
	localparam logic [CNT_W-1:0] VFNPRCH_VGA = 11'd11; // Longer than the usual 10
	localparam logic [CNT_W-1:0] VSYNCPW_VGA = 11'd2;
	localparam logic [CNT_W-1:0] VBKPRCH_VGA = 11'd31;
	localparam logic             HVSYNC_NEG_VGA = 1'b1;

	// 800x600@60
	localparam logic [CNT_W-1:0] HPIXELS_SVGA = 11'd800;
	localparam logic [CNT_W-1:0] HFNPRCH_SVGA = 11'd40;
	localparam logic [CNT_W-1:0] HSYNCPW_SVGA = 11'd128;
	localparam logic [CNT_W-1:0] HBKPRCH_SVGA = 11'd88;
	localparam logic [CNT_W-1:0] VLINES_SVGA  = 11'd600;
	localparam logic [CNT_W-1:0] VFNPRCH_SVGA = 11'd1;
	localparam logic [CNT_W-1:0] VSYNCPW_SVGA = 11'd4;
	localparam logic [CNT_W-1:0] VBKPRCH_SVGA = 11'd23;
	localparam logic             HVSYNC_NEG_SVGA = 1'b0;

	// 1024x768@60
	localparam logic [CNT_W-1:0] HPIXELS_XGA = 11'd1024;
	localparam logic [CNT_W-1:0] HFNPRCH_XGA = 11'd24;
	localparam logic [CNT_W-1:0] HSYNCPW_XGA = 11'd136;
	localparam logic [CNT_W-1:0] HBKPRCH_XGA = 11'd160;
	localparam logic [CNT_W-1:0] VLINES_XGA  = 11'd768;
	localparam logic [CNT_W-1:0] VFNPRCH_XGA = 11'd3;
	localparam logic [CNT_W-1:0] VSYNCPW_XGA = 11'd6;
	localparam logic [CNT_W-1:0] VBKPRCH_XGA = 11'd29;
	localparam logic             HVSYNC_NEG_XGA = 1'b1;

	// 1280x720@60
	localparam logic [CNT_W-1:0] HPIXELS_HDTV720P = 11'd1280;
	localparam logic [CNT_W-1:0] HFNPRCH_HDTV720P = 11'd110;
	localparam logic [CNT_W-1:0] HSYNCPW_HDTV720P = 11'd40;
	localparam logic [CNT_W-1:0] HBKPRCH_HDTV720P = 11'd220;
	localparam logic [CNT_W-1:0] VLINES_HDTV720P  = 11'd720;
	localparam logic [CNT_W-1:0] VFNPRCH_HDTV720P = 11'd5;
	localparam logic [CNT_W-1:0] VSYNCPW_HDTV720P = 11'd5;
	localparam logic [CNT_W-1:0] VBKPRCH_HDTV720P = 11'd20;
	localparam logic             HVSYNC_NEG_HDTV720P = 1'b0;

	// 1280x1024@60
	localparam logic [CNT_W-1:0] HPIXELS_SXGA = 11'd1280;
	localparam logic [CNT_W-1:0] HFNPRCH_SXGA = 11'd48;
	localparam logic [CNT_W-1:0] HSYNCPW_SXGA = 11'd112;
	localparam logic [CNT_W-1:0] HBKPRCH_SXGA = 11'd248;
	localparam logic [CNT_W-1:0] VLINES_SXGA  = 11'd1024;
	localparam logic [CNT_W-1:0] VFNPRCH_SXGA = 11'd1;
	localparam logic [CNT_W-1:0] VSYNCPW_SXGA = 11'd3;
	localparam logic [CNT_W-1:0] VBKPRCH_SXGA = 11'd38;
	localparam logic             HVSYNC_NEG_SXGA = 1'b0;

	// Camera raster, 720p with trimmed sync
	localparam logic [CNT_W-1:0] HPIXELS_CAMERA = 11'd1280;
	localparam logic [CNT_W-1:0] HFNPRCH_CAMERA = 11'd110;
	localparam logic [CNT_W-1:0] HSYNCPW_CAMERA = 11'd39;
	localparam logic [CNT_W-1:0] HBKPRCH_CAMERA = 11'd220;
	localparam logic [CNT_W-1:0] VLINES_CAMERA  = 11'd720;
	localparam logic [CNT_W-1:0] VFNPRCH_CAMERA = 11'd4;
	localparam logic [CNT_W-1:0] VSYNCPW_CAMERA = 11'd4;
	localparam logic [CNT_W-1:0] VBKPRCH_CAMERA = 11'd22;
	localparam logic             HVSYNC_NEG_CAMERA = 1'b0;

	// Terminal counts of one mode
	typedef struct packed {
		logic [CNT_W-1:0] hsblnk; // Last active pixel
		logic [CNT_W-1:0] hssync;
		logic [CNT_W-1:0] hesync;
		logic [CNT_W-1:0] heblnk; // Last pixel of the line
		logic [CNT_W-1:0] vsblnk;
		logic [CNT_W-1:0] vssync;
		logic [CNT_W-1:0] vesync;
		logic [CNT_W-1:0] veblnk;
		logic             neg_pol; // 1 for low-active sync
	} tc_word_t;

	// Current raster position
	typedef struct packed {
		logic [CNT_W-1:0] hcount;
		logic [CNT_W-1:0] vcount;
	} raster_pos_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic de;
	} raster_sig_t;

endpackage

`default_nettype wire

/* panel_ctrl_pkg.sv */
`default_nettype none

package panel_ctrl_pkg;

	localparam int SW_W = 4; // Mode switches on the panel

	////////////////////////////////////////
	// Switch codes
	////////////////////////////////////////

	localparam logic [SW_W-1:0] SW_VGA      = 4'b0000;
	localparam logic [SW_W-1:0] SW_SVGA     = 4'b0001;
	localparam logic [SW_W-1:0] SW_XGA      = 4'b0011;
	localparam logic [SW_W-1:0] SW_HDTV720P = 4'b0010;
	localparam logic [SW_W-1:0] SW_SXGA     = 4'b1000;
	localparam logic [SW_W-1:0] SW_CAMERA   = 4'b1001;

	////////////////////////////////////////
	// Debounce
	////////////////////////////////////////

	// Equal samples before a code counts as settled
	localparam int DEBOUNCE_CYCLES = 16;

	// Counter holds 0 to DEBOUNCE_CYCLES-1
	localparam int DB_CNT_W = $clog2(DEBOUNCE_CYCLES);

endpackage

`default_nettype wire

/* mode_switch.sv */
`timescale 1ns/10ps
`default_nettype none

module mode_switch
	import panel_ctrl_pkg::*;
	import vid_timing_pkg::*;
(
	input  logic            clk50m_bufg,
	input  logic            RSTBTN,
	input  logic [SW_W-1:0] sw,        // Straight from the panel
	output vid_mode_e       mode,      // Current mode
	output logic            mode_load  // One cycle per mode change
);

	logic [SW_W-1:0]     sw_meta;    // First sync stage
	logic [SW_W-1:0]     sw_sync;    // Second sync stage
	logic [SW_W-1:0]     sw_last;    // Code being timed
	logic [DB_CNT_W-1:0] stable_cnt;
	logic                settled;
	logic                loaded;     // A mode has gone out since reset
	vid_mode_e           new_mode;

	// Unlisted codes fall back to 720p
	function automatic vid_mode_e code_to_mode(input logic [SW_W-1:0] code);
		case (code)
			SW_VGA:      return MODE_VGA;
			SW_SVGA:     return MODE_SVGA;
			SW_XGA:      return MODE_XGA;
			SW_HDTV720P: return MODE_HDTV720P;
			SW_SXGA:     return MODE_SXGA;
			SW_CAMERA:   return MODE_CAMERA;
			default:     return MODE_HDTV720P;
		endcase
	endfunction

	////////////////////////////////////////
	// Two-flop synchronizer
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_meta <= '0;
			sw_sync <= '0;
		end else begin
			sw_meta <= sw;
			sw_sync <= sw_meta;
		end
	end

	////////////////////////////////////////
	// Stability counter
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sw_last    <= '0;
			stable_cnt <= '0;
		end else if (sw_sync != sw_last) begin
			sw_last    <= sw_sync; // New code, start over
			stable_cnt <= '0;
		end else if (!settled) begin
			stable_cnt <= stable_cnt + 1'b1;
		end
	end

	assign settled  = (stable_cnt == DB_CNT_W'(DEBOUNCE_CYCLES - 1)); // Saturates here
	assign new_mode = code_to_mode(sw_last);

	// Load only on a real change, or the first settle after reset
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			mode      <= MODE_VGA;
			mode_load <= 1'b0;
			loaded    <= 1'b0;
		end else begin
			mode_load <= 1'b0;
			if (settled && (!loaded || (new_mode != mode))) begin
				mode      <= new_mode;
				mode_load <= 1'b1;
				loaded    <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* mode_table.sv */
`timescale 1ns/10ps
`default_nettype none

module mode_table
	import vid_timing_pkg::*;
(
	input  vid_mode_e mode,
	output tc_word_t  tc    // Terminal counts and polarity
);

	// Each count is the previous one plus the next interval
	function automatic tc_word_t build_tc(
		input logic [CNT_W-1:0] hpix,
		input logic [CNT_W-1:0] hfp,
		input logic [CNT_W-1:0] hsw,
		input logic [CNT_W-1:0] hbp,
		input logic [CNT_W-1:0] vlin,
		input logic [CNT_W-1:0] vfp,
		input logic [CNT_W-1:0] vsw,
		input logic [CNT_W-1:0] vbp,
		input logic             neg
	);
		tc_word_t t;
		t.hsblnk  = hpix - 1'b1;    // Last live pixel
		t.hssync  = t.hsblnk + hfp;
		t.hesync  = t.hssync + hsw;
		t.heblnk  = t.hesync + hbp; // Line length minus one
		t.vsblnk  = vlin - 1'b1;
		t.vssync  = t.vsblnk + vfp;
		t.vesync  = t.vssync + vsw;
		t.veblnk  = t.vesync + vbp;
		t.neg_pol = neg;
		return t;
	endfunction

	always_comb begin
		case (mode)
			MODE_VGA: tc = build_tc(HPIXELS_VGA, HFNPRCH_VGA, HSYNCPW_VGA, HBKPRCH_VGA,
				VLINES_VGA, VFNPRCH_VGA, VSYNCPW_VGA, VBKPRCH_VGA, HVSYNC_NEG_VGA);

			MODE_SVGA: tc = build_tc(HPIXELS_SVGA, HFNPRCH_SVGA, HSYNCPW_SVGA, HBKPRCH_SVGA,
				VLINES_SVGA, VFNPRCH_SVGA, VSYNCPW_SVGA, VBKPRCH_SVGA, HVSYNC_NEG_SVGA);

			MODE_XGA: tc = build_tc(HPIXELS_XGA, HFNPRCH_XGA, HSYNCPW_XGA, HBKPRCH_XGA,
				VLINES_XGA, VFNPRCH_XGA, VSYNCPW_XGA, VBKPRCH_XGA, HVSYNC_NEG_XGA);

			MODE_SXGA: tc = build_tc(HPIXELS_SXGA, HFNPRCH_SXGA, HSYNCPW_SXGA, HBKPRCH_SXGA,
				VLINES_SXGA, VFNPRCH_SXGA, VSYNCPW_SXGA, VBKPRCH_SXGA, HVSYNC_NEG_SXGA);

			MODE_CAMERA: tc = build_tc(HPIXELS_CAMERA, HFNPRCH_CAMERA, HSYNCPW_CAMERA,
				HBKPRCH_CAMERA, VLINES_CAMERA, VFNPRCH_CAMERA, VSYNCPW_CAMERA,
				VBKPRCH_CAMERA, HVSYNC_NEG_CAMERA);

			// 720p, also the fallback
			default: tc = build_tc(HPIXELS_HDTV720P, HFNPRCH_HDTV720P, HSYNCPW_HDTV720P,
				HBKPRCH_HDTV720P, VLINES_HDTV720P, VFNPRCH_HDTV720P, VSYNCPW_HDTV720P,
				VBKPRCH_HDTV720P, HVSYNC_NEG_HDTV720P);
		endcase
	end

endmodule

`default_nettype wire

/* raster_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module raster_gen
	import vid_timing_pkg::*;
(
	input  logic        clk50m_bufg,
	input  logic        RSTBTN,
	input  tc_word_t    tc,          // From the mode table
	input  logic        mode_load,   // Restart the raster
	output raster_sig_t video_sync   // Two cycles behind the count
);

	raster_pos_t pos;
	raster_sig_t sig_raw;   // Decoded from pos
	raster_sig_t sig_q;     // First pipeline stage
	logic        running;   // Set by the first load
	logic        line_end;
	logic        frame_end;
	logic        hblank;
	logic        vblank;
	logic        hsync_int;
	logic        vsync_int;

	////////////////////////////////////////
	// Counters
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			running <= 1'b0;
		end else if (mode_load) begin
			running <= 1'b1;
		end
	end

	assign line_end  = (pos.hcount == tc.heblnk);
	assign frame_end = (pos.vcount == tc.veblnk);

	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN || mode_load || !running) begin
			pos <= '0; // Park at the origin
		end else if (line_end) begin
			pos.hcount <= '0;
			pos.vcount <= frame_end ? '0 : pos.vcount + 1'b1;
		end else begin
			pos.hcount <= pos.hcount + 1'b1;
		end
	end

	////////////////////////////////////////
	// Blank and sync decode
	////////////////////////////////////////
	assign hblank    = (pos.hcount > tc.hsblnk);
	assign vblank    = (pos.vcount > tc.vsblnk);
	assign hsync_int = (pos.hcount > tc.hssync) && (pos.hcount <= tc.hesync);
	assign vsync_int = (pos.vcount > tc.vssync) && (pos.vcount <= tc.vesync);

	always_comb begin
		if (!running) begin
			sig_raw = '0; // Quiet until a mode is loaded
		end else begin
			sig_raw.hsync = hsync_int ^ tc.neg_pol;
			sig_raw.vsync = vsync_int ^ tc.neg_pol;
			sig_raw.de    = !hblank && !vblank;
		end
	end

	////////////////////////////////////////
	// Output pipeline
	////////////////////////////////////////
	always_ff @(posedge clk50m_bufg) begin
		if (RSTBTN) begin
			sig_q      <= '0;
			video_sync <= '0;
		end else begin
			sig_q      <= sig_raw;
			video_sync <= sig_q; // Sync and de stay aligned
		end
	end

endmodule

`default_nettype wire

/* video_timing_top.sv */
`timescale 1ns/10ps
`default_nettype none

module video_timing_top
	import panel_ctrl_pkg::*;
	import vid_timing_pkg::*;
(
	input  logic            clk50m_bufg,
	input  logic            RSTBTN,
	input  logic [SW_W-1:0] sw,          // Asynchronous mode switches
	output raster_sig_t     video_sync,
	output vid_mode_e       mode         // Status level
);

	logic     mode_load; // Restart pulse
	tc_word_t tc;

	// Switch handling
	mode_switch u_mode_switch (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.mode        (mode),
		.mode_load   (mode_load)
	);

	// Mode to terminal counts
	mode_table u_mode_table (
		.mode (mode),
		.tc   (tc)
	);

	// Counters, decode and output stages
	raster_gen u_raster_gen (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.tc          (tc),
		.mode_load   (mode_load),
		.video_sync  (video_sync)
	);

endmodule

`default_nettype wire

/* tb_video_ref.svh */
`ifndef TB_VIDEO_REF_SVH
`define TB_VIDEO_REF_SVH

// Expected raster figures for one switch code
typedef struct packed {
	int        line_len;     // Cycles per line
	int        active;       // de cycles per line
	int        hsync_w;      // Active-level hsync cycles
	int        frame_lines;  // Lines per frame
	int        vsync_lines;  // Active-level vsync lines
	logic      neg_pol;      // Low-active sync
	vid_mode_e mode;
} ref_timing_t;

// Sums of the porch and sync intervals
function automatic ref_timing_t from_intervals(input vid_mode_e mode,
	input int hpix, input int hfp, input int hsw, input int hbp,
	input int vlin, input int vfp, input int vsw, input int vbp, input logic neg);
	ref_timing_t r;
	r.line_len    = hpix + hfp + hsw + hbp;
	r.active      = hpix;
	r.hsync_w     = hsw;
	r.frame_lines = vlin + vfp + vsw + vbp;
	r.vsync_lines = vsw;
	r.neg_pol     = neg;
	r.mode        = mode;
	return r;
endfunction

// Unlisted codes give the 720p figures
function automatic ref_timing_t ref_timing(input logic [SW_W-1:0] code);
	case (code)
		SW_VGA: return from_intervals(MODE_VGA, HPIXELS_VGA, HFNPRCH_VGA, HSYNCPW_VGA,
			HBKPRCH_VGA, VLINES_VGA, VFNPRCH_VGA, VSYNCPW_VGA, VBKPRCH_VGA, HVSYNC_NEG_VGA);
		SW_SVGA: return from_intervals(MODE_SVGA, HPIXELS_SVGA, HFNPRCH_SVGA, HSYNCPW_SVGA,
			HBKPRCH_SVGA, VLINES_SVGA, VFNPRCH_SVGA, VSYNCPW_SVGA, VBKPRCH_SVGA, HVSYNC_NEG_SVGA);
		SW_XGA: return from_intervals(MODE_XGA, HPIXELS_XGA, HFNPRCH_XGA, HSYNCPW_XGA,
			HBKPRCH_XGA, VLINES_XGA, VFNPRCH_XGA, VSYNCPW_XGA, VBKPRCH_XGA, HVSYNC_NEG_XGA);
		SW_SXGA: return from_intervals(MODE_SXGA, HPIXELS_SXGA, HFNPRCH_SXGA, HSYNCPW_SXGA,
			HBKPRCH_SXGA, VLINES_SXGA, VFNPRCH_SXGA, VSYNCPW_SXGA, VBKPRCH_SXGA, HVSYNC_NEG_SXGA);
		SW_CAMERA: return from_intervals(MODE_CAMERA, HPIXELS_CAMERA, HFNPRCH_CAMERA,
			HSYNCPW_CAMERA, HBKPRCH_CAMERA, VLINES_CAMERA, VFNPRCH_CAMERA, VSYNCPW_CAMERA,
			VBKPRCH_CAMERA, HVSYNC_NEG_CAMERA);
		default: return from_intervals(MODE_HDTV720P, HPIXELS_HDTV720P, HFNPRCH_HDTV720P,
			HSYNCPW_HDTV720P, HBKPRCH_HDTV720P, VLINES_HDTV720P, VFNPRCH_HDTV720P,
			VSYNCPW_HDTV720P, VBKPRCH_HDTV720P, HVSYNC_NEG_HDTV720P);
	endcase
endfunction

`endif

/* tb_video_timing.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_video_timing
	import vid_timing_pkg::*;
	import panel_ctrl_pkg::*;
();

	localparam int RESET_CYCLES  = 10;
	localparam int SETTLE_CYCLES = 2 + DEBOUNCE_CYCLES + 1 + 2 + 4; // Switch to new timing
	localparam int GLITCH_COUNT  = 12;

	typedef enum logic [2:0] {
		K_LINE, K_HSW, K_ACTIVE, K_FRAME, K_VSW, K_HIDLE, K_MODE, K_EARLY_DE
	} meas_kind_e;

	// One measured figure
	typedef struct packed {
		meas_kind_e      kind;
		logic [SW_W-1:0] code;  // Switch code in force
		logic [31:0]     value;
	} meas_rec_t;

	logic            clk50m_bufg;
	logic            RSTBTN;
	logic [SW_W-1:0] sw;
	raster_sig_t     video_sync;
	vid_mode_e       mode;

	meas_rec_t       meas_q[$];    // Measurement to compare
	logic            meas_en;      // Measurement window open
	logic [SW_W-1:0] meas_code;    // Code the timing is judged against
	int              lines_seen;
	int              frames_seen;
	int              checks = 0;
	int              errors = 0;
	logic [31:0]     rng_state;

	// Edge trackers of the measurement process
	logic h_prev, v_prev, de_prev;
	logic h_armed, hw_ok, de_ok, v_armed, vw_ok;
	int   h_cnt, hw_cnt, de_cnt, v_lines, vw_cnt;

	`include "tb_video_ref.svh"

	video_timing_top uut (
		.clk50m_bufg (clk50m_bufg),
		.RSTBTN      (RSTBTN),
		.sw          (sw),
		.video_sync  (video_sync),
		.mode        (mode)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic string kind_name(input meas_kind_e k);
		case (k)
			K_LINE:   return "line length";
			K_HSW:    return "hsync width";
			K_ACTIVE: return "de run length";
			K_FRAME:  return "frame lines";
			K_VSW:    return "vsync width";
			K_HIDLE:  return "hsync idle level";
			K_MODE:   return "mode";
			default:  return "de before load";
		endcase
	endfunction

	function automatic int expected_value(input meas_rec_t rec);
		ref_timing_t r;
		r = ref_timing(rec.code);
		case (rec.kind)
			K_LINE:   return r.line_len;
			K_HSW:    return r.hsync_w;
			K_ACTIVE: return r.active;
			K_FRAME:  return r.frame_lines;
			K_VSW:    return r.vsync_lines * r.line_len; // In cycles
			K_HIDLE:  return r.neg_pol;                  // Inactive level
			K_MODE:   return int'(r.mode);
			default:  return 0;
		endcase
	endfunction

	task automatic push_meas(input meas_kind_e kind, input int value);
		meas_rec_t rec;
		rec.kind  = kind;
		rec.code  = meas_code;
		rec.value = value;
		meas_q.push_back(rec);
	endtask

	// Switch, let it settle, then measure
	task automatic run_mode(input logic [SW_W-1:0] code, input int frames, input int lines);
		meas_en = 1'b0;
		@(posedge clk50m_bufg);
		sw <= code;
		repeat (SETTLE_CYCLES) @(posedge clk50m_bufg);
		meas_code   = code;
		lines_seen  = 0;
		frames_seen = 0;
		meas_en     = 1'b1;
		while (frames_seen < frames || lines_seen < lines) @(posedge clk50m_bufg);
		meas_en = 1'b0;
	endtask

	// Short bursts of other codes on top of SVGA
	task automatic glitch_test(input int count);
		int glen;
		meas_code  = SW_SVGA;
		lines_seen = 0;
		meas_en    = 1'b1;
		while (lines_seen < 1) @(posedge clk50m_bufg); // Line tracking armed before the bursts
		for (int i = 0; i < count; i++) begin
			rng_state = xorshift32(rng_state);
			glen = 1 + (rng_state % (DEBOUNCE_CYCLES - 1)); // Always below the debounce length
			@(posedge clk50m_bufg);
			sw <= rng_state[11:8];
			repeat (glen) @(posedge clk50m_bufg);
			sw <= SW_SVGA;
			rng_state = xorshift32(rng_state);
			repeat (4 + rng_state % 60) @(posedge clk50m_bufg);
		end
		while (lines_seen < 4) @(posedge clk50m_bufg);
		meas_en = 1'b0;
	endtask

	initial begin
		clk50m_bufg = 1'b0;
		forever #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz
	end

	////////////////////////////////////////
	// Measurement
	////////////////////////////////////////
	always @(negedge clk50m_bufg) begin : measure
		ref_timing_t r_now;
		logic h_act;
		logic v_act;
		r_now = ref_timing(meas_code);
		h_act = video_sync.hsync ^ r_now.neg_pol; // Active level
		v_act = video_sync.vsync ^ r_now.neg_pol;
		if (RSTBTN || !meas_en) begin
			h_armed = 1'b0;
			hw_ok   = 1'b0;
			de_ok   = 1'b0;
			v_armed = 1'b0;
			vw_ok   = 1'b0;
		end else begin
			if (h_act && !h_prev) begin // Line start
				if (h_armed) begin
					push_meas(K_LINE, h_cnt);
					lines_seen++;
				end
				push_meas(K_MODE, mode);
				h_armed = 1'b1;
				h_cnt   = 0;
				hw_cnt  = 0;
				hw_ok   = 1'b1;
				v_lines++;
			end
			h_cnt++;
			if (h_act)
				hw_cnt++;
			if (!h_act && h_prev && hw_ok)
				push_meas(K_HSW, hw_cnt);
			if (video_sync.de && !de_prev) begin
				de_cnt = 0;
				de_ok  = 1'b1;
				push_meas(K_HIDLE, video_sync.hsync); // Sync idle during data
			end
			if (video_sync.de)
				de_cnt++;
			if (!video_sync.de && de_prev && de_ok)
				push_meas(K_ACTIVE, de_cnt);
			if (v_act && !v_prev) begin // Frame start
				if (v_armed) begin
					push_meas(K_FRAME, v_lines);
					frames_seen++;
				end
				v_armed = 1'b1;
				v_lines = 0;
				vw_cnt  = 0;
				vw_ok   = 1'b1;
			end
			if (v_act)
				vw_cnt++;
			if (!v_act && v_prev && vw_ok)
				push_meas(K_VSW, vw_cnt);
		end
		h_prev  = h_act;
		v_prev  = v_act;
		de_prev = video_sync.de;
	end

	////////////////////////////////////////
	// Comparison
	////////////////////////////////////////
	always @(posedge clk50m_bufg) begin : compare
		meas_rec_t rec;
		int        exp_v;
		while (meas_q.size() > 0) begin
			rec   = meas_q.pop_front();
			exp_v = expected_value(rec);
			checks++;
			assert (rec.value == exp_v) else begin
				errors++;
				$display("Mismatch at %0t ns: %s expected %0d, actual %0d",
					$time, kind_name(rec.kind), exp_v, rec.value);
			end
		end
	end

	// Three 720p frames plus switching time
	initial begin : watchdog
		ref_timing_t big;
		int          budget;
		big    = ref_timing(SW_HDTV720P);
		budget = 3 * big.line_len * big.frame_lines + 8 * SETTLE_CYCLES + 20000;
		repeat (budget) @(posedge clk50m_bufg);
		$display("Timeout: test did not finish within %0d cycles", budget);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		$display("SIMULATION FAILED");
		$finish;
	end

	initial begin : stimulus
		RSTBTN      = 1'b1;
		sw          = SW_VGA;
		meas_en     = 1'b0;
		meas_code   = SW_VGA;
		lines_seen  = 0;
		frames_seen = 0;
		v_lines     = 0;
		rng_state   = 32'd69;
		repeat (RESET_CYCLES) @(posedge clk50m_bufg);
		RSTBTN <= 1'b0;
		repeat (DEBOUNCE_CYCLES) begin // Raster still parked
			@(negedge clk50m_bufg);
			push_meas(K_EARLY_DE, video_sync.de);
		end
		run_mode(SW_VGA, 1, 4);
		run_mode(SW_SVGA, 1, 4);
		glitch_test(GLITCH_COUNT);
		run_mode(4'b0111, 0, 6); // Unlisted code
		repeat (2) @(posedge clk50m_bufg);
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0 && checks > 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* video_timing_top.f */
+incdir+.
vid_timing_pkg.sv
panel_ctrl_pkg.sv
mode_switch.sv
mode_table.sv
raster_gen.sv
video_timing_top.sv
tb_video_timing.sv
